// File: filelist.f
rtl/uart_pkg.sv
rtl/uart_tx_shifter.sv
rtl/uart_rx_sampler.sv
rtl/uart_cmd_ctrl.sv
rtl/uart_top.sv
testbench/tb_uart.sv

// File: run_sim.sh
#!/bin/sh
# build and run the UART testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
   --top-module tb_uart \
   -f filelist.f \
   -o sim_uart

./obj_dir/sim_uart > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
   echo "simulation reported failure"
   exit 1
fi

echo "simulation finished without failure"
exit 0

// File: testbench/tb_uart.sv
`timescale 1ns/1ps

module tb_uart;

   localparam int cpb = uart_pkg::clks_per_bit;
   localparam int half = uart_pkg::half_bit;
   localparam int start_wait = 20 * cpb;       // cycles allowed before a start bit
   localparam int rdy_wait = 30 * cpb;
   localparam int rx_wait = 30 * cpb;

   logic                 clk;
   logic                 rst_n;
   logic [15:0]          cmd_in;
   logic                 cmd_vld;
   logic                 cmd_rdy;
   logic                 rx;
   logic                 rx_line;
   logic                 loop_en;
   logic                 tx;
   logic                 read_vld;
   uart_pkg::rx_result_t read_res;

   int                   errors;
   int                   timeouts;
   int                   rdy_early;
   logic                 watch_busy;
   integer               seed;
   uart_pkg::rx_result_t rx_q[$];

   assign rx = loop_en ? tx : rx_line;          // loopback for the last test

   uart_top uart_top_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .cmd_in   (cmd_in),
      .cmd_vld  (cmd_vld),
      .cmd_rdy  (cmd_rdy),
      .rx       (rx),
      .tx       (tx),
      .read_vld (read_vld),
      .read_res (read_res)
   );

   always #20 clk = ~clk;

   // read port and busy monitor on the falling edge
   always @(negedge clk) begin
      if (rst_n && read_vld) begin
         rx_q.push_back(read_res);
      end
      if (watch_busy && cmd_rdy) begin
         rdy_early++;
      end
   end

   // ============================================================
   // helpers
   // ============================================================

   task automatic check_val(input string name, input logic [15:0] actual,
                            input logic [15:0] expected);
      if (actual !== expected) begin
         $display("Error %s: got 0x%0h, expected 0x%0h", name, actual, expected);
         errors++;
      end
   endtask

   task automatic next_slot;
      @(posedge clk);
      #2;
   endtask

   task automatic wait_rdy;
      int cnt;
      cnt = 0;
      @(negedge clk);
      while (!cmd_rdy && cnt < rdy_wait) begin
         @(negedge clk);
         cnt++;
      end
      if (!cmd_rdy) begin
         $display("timeout: cmd_rdy never returned high");
         timeouts++;
      end
   endtask

   // offers a command and returns just after the handshake edge
   task automatic offer_cmd(input logic [15:0] value);
      next_slot();
      cmd_in  = value;
      cmd_vld = 1'b1;
      wait_rdy();
      next_slot();
   endtask

   task automatic capture_frame(output logic [10:0] bits, output int delay);
      int i;
      bits  = '1;
      delay = 0;
      @(negedge clk);
      while (tx !== 1'b0 && delay < start_wait) begin
         @(negedge clk);
         delay++;
      end
      if (tx !== 1'b0) begin
         $display("timeout: no start bit appeared on tx");
         timeouts++;
      end else begin
         repeat (half - 1) @(negedge clk);    // roughly mid start bit
         for (i = 0; i < 11; i++) begin
            if (i > 0) begin
               repeat (cpb) @(negedge clk);
            end
            bits[i] = tx;
         end
      end
   endtask

   task automatic check_frame(input logic [10:0] bits, input logic [7:0] data);
      logic exp_par;
      exp_par = ~(^data);
      check_val("tx start bit", bits[0], 1'b0);
      check_val("tx data", bits[8:1], data);
      check_val("tx parity bit", bits[9], exp_par);
      check_val("tx stop bit", bits[10], 1'b1);
   endtask

   task automatic send_frame(input logic [7:0] data, input logic par, input logic stop);
      logic [10:0] frame;
      int          i;
      frame = {stop, par, data, 1'b0};
      for (i = 0; i < 11; i++) begin
         next_slot();
         rx_line = frame[i];
         repeat (cpb - 1) @(posedge clk);
      end
      next_slot();
      rx_line = 1'b1;
   endtask

   task automatic wait_rx(input int n);
      int cnt;
      cnt = 0;
      while (rx_q.size() < n && cnt < rx_wait) begin
         @(negedge clk);
         cnt++;
      end
      if (rx_q.size() < n) begin
         $display("timeout: expected %0d receive results but saw %0d", n, rx_q.size());
         timeouts++;
      end
   endtask

   task automatic check_result(input logic [7:0] data, input logic par_err,
                               input logic frm_err);
      uart_pkg::rx_result_t res;
      if (rx_q.size() > 0) begin
         res = rx_q.pop_front();
         check_val("read_res.data", res.data, data);
         check_val("read_res.parity_err", res.parity_err, par_err);
         check_val("read_res.frame_err", res.frame_err, frm_err);
      end
   endtask

   task automatic receive_one(input logic [7:0] data, input logic par, input logic stop,
                              input logic par_err, input logic frm_err);
      rx_q.delete();
      send_frame(data, par, stop);
      wait_rx(1);
      repeat (2 * cpb) @(negedge clk);       // a second pulse would show up here
      check_val("read_vld pulses", rx_q.size(), 1);
      check_result(data, par_err, frm_err);
   endtask

   // ============================================================
   // tests
   // ============================================================

   task automatic test_reset_state;
      int bad;
      bad = 0;
      @(negedge clk);
      check_val("tx", tx, 1'b1);
      check_val("cmd_rdy", cmd_rdy, 1'b1);
      check_val("read_vld", read_vld, 1'b0);
      repeat (50) begin
         @(negedge clk);
         if (tx !== 1'b1) begin
            bad++;
         end
      end
      check_val("idle tx low cycles", bad, 0);
   endtask

   task automatic transmit_cmd(input logic [15:0] value);
      logic [10:0] bits;
      int          delay;
      offer_cmd(value);
      cmd_vld = 1'b0;
      capture_frame(bits, delay);
      check_val("start delay ok", delay <= 3, 1'b1);
      check_frame(bits, value[7:0]);
      capture_frame(bits, delay);
      check_frame(bits, value[15:8]);
      check_val("cmd_rdy in stop bit", cmd_rdy, 1'b0);
      wait_rdy();
   endtask

   task automatic test_back_pressure;
      logic [10:0] bits;
      int          delay;
      offer_cmd(16'h1E87);
      cmd_in     = 16'h6B42;                   // held with cmd_vld still high
      rdy_early  = 0;
      watch_busy = 1'b1;
      capture_frame(bits, delay);
      check_frame(bits, 8'h87);
      capture_frame(bits, delay);
      check_frame(bits, 8'h1E);
      watch_busy = 1'b0;
      check_val("cmd_rdy high while busy", rdy_early, 0);
      offer_cmd(16'h6B42);
      cmd_vld = 1'b0;
      capture_frame(bits, delay);
      check_frame(bits, 8'h42);
      capture_frame(bits, delay);
      check_frame(bits, 8'h6B);
      wait_rdy();
   endtask

   task automatic test_clean_receive;
      logic [31:0] r;
      logic [7:0]  b;
      int          k;
      receive_one(8'h00, 1'b1, 1'b1, 1'b0, 1'b0);
      receive_one(8'hFF, 1'b1, 1'b1, 1'b0, 1'b0);
      for (k = 0; k < 6; k++) begin
         r = $random(seed);
         b = r[7:0];
         receive_one(b, ~(^b), 1'b1, 1'b0, 1'b0);
      end
   endtask

   task automatic test_receive_errors;
      receive_one(8'h5A, ^8'h5A, 1'b1, 1'b1, 1'b0);    // parity inverted
      receive_one(8'hC3, ~(^8'hC3), 1'b0, 1'b0, 1'b1); // stop bit low
   endtask

   task automatic test_loopback;
      logic [31:0] r;
      logic [15:0] v;
      int          k;
      next_slot();
      loop_en = 1'b1;
      for (k = 0; k < 3; k++) begin
         r = $random(seed);
         v = r[15:0];
         rx_q.delete();
         offer_cmd(v);
         cmd_vld = 1'b0;
         wait_rx(2);
         check_result(v[7:0], 1'b0, 1'b0);
         check_result(v[15:8], 1'b0, 1'b0);
         wait_rdy();
      end
      next_slot();
      loop_en = 1'b0;
   endtask

   // ============================================================
   // main sequence
   // ============================================================

   initial begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      cmd_in     = '0;
      cmd_vld    = 1'b0;
      rx_line    = 1'b1;
      loop_en    = 1'b0;
      watch_busy = 1'b0;
      errors     = 0;
      timeouts   = 0;
      rdy_early  = 0;
      seed       = 32'h27b3_bb0a;
      repeat (8) @(posedge clk);
      #2;
      rst_n = 1'b1;

      test_reset_state();
      transmit_cmd(16'hA53C);
      test_back_pressure();
      test_clean_receive();
      test_receive_errors();
      test_loopback();

      $display("errors: %0d  timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// File: rtl/uart_top.sv
`timescale 1ns/1ps

module uart_top (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [15:0]          cmd_in,
   input  logic                 cmd_vld,
   output logic                 cmd_rdy,
   input  logic                 rx,
   output logic                 tx,
   output logic                 read_vld,
   output uart_pkg::rx_result_t read_res
);

   logic                 tx_req;
   uart_pkg::tx_req_t    tx_byte;
   logic                 tx_ack;
   logic                 rx_vld;
   uart_pkg::rx_result_t rx_res;

   uart_cmd_ctrl uart_cmd_ctrl_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .cmd_in   (cmd_in),
      .cmd_vld  (cmd_vld),
      .cmd_rdy  (cmd_rdy),
      .tx_req   (tx_req),
      .tx_byte  (tx_byte),
      .tx_ack   (tx_ack),
      .rx_vld   (rx_vld),
      .rx_res   (rx_res),
      .read_vld (read_vld),
      .read_res (read_res)
   );

   uart_tx_shifter uart_tx_shifter_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .tx_req  (tx_req),
      .tx_byte (tx_byte),
      .tx_ack  (tx_ack),
      .tx      (tx)
   );

   uart_rx_sampler uart_rx_sampler_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .rx     (rx),
      .rx_vld (rx_vld),
      .rx_res (rx_res)
   );

endmodule

// File: rtl/uart_cmd_ctrl.sv
`timescale 1ns/1ps

module uart_cmd_ctrl (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [15:0]          cmd_in,
   input  logic                 cmd_vld,
   output logic                 cmd_rdy,
   output logic                 tx_req,
   output uart_pkg::tx_req_t    tx_byte,
   input  logic                 tx_ack,
   input  logic                 rx_vld,
   input  uart_pkg::rx_result_t rx_res,
   output logic                 read_vld,
   output uart_pkg::rx_result_t read_res
);

   uart_pkg::ctrl_state_t state;
   uart_pkg::ctrl_state_t state_nxt;
   logic [15:0]           cmd_q;

   // ============================================================
   // command sequencer
   // ============================================================

   assign cmd_rdy = (state == uart_pkg::idle);
   assign tx_req  = (state == uart_pkg::send_lo) || (state == uart_pkg::send_hi);

   // byte select holds steady over each whole req/ack cycle
   assign tx_byte.data = ((state == uart_pkg::send_hi) || (state == uart_pkg::wait_hi))
                         ? cmd_q[15:8] : cmd_q[7:0];

   always_comb begin
      state_nxt = state;
      unique case (state)
         uart_pkg::idle:    if (cmd_vld) state_nxt = uart_pkg::send_lo;
         uart_pkg::send_lo: if (tx_ack)  state_nxt = uart_pkg::wait_lo;
         uart_pkg::wait_lo: if (!tx_ack) state_nxt = uart_pkg::send_hi;
         uart_pkg::send_hi: if (tx_ack)  state_nxt = uart_pkg::wait_hi;
         uart_pkg::wait_hi: if (!tx_ack) state_nxt = uart_pkg::idle;
         default:           state_nxt = uart_pkg::idle;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= uart_pkg::idle;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (cmd_vld && cmd_rdy) begin
         cmd_q <= cmd_in;                      // held until both bytes are out
      end
   end

   // ============================================================
   // read port
   // ============================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         read_vld <= 1'b0;
      end else begin
         read_vld <= rx_vld;
      end
   end

   always_ff @(posedge clk) begin
      if (rx_vld) begin
         read_res <= rx_res;                   // no back-pressure, newest wins
      end
   end

endmodule

// File: rtl/uart_rx_sampler.sv
`timescale 1ns/1ps

module uart_rx_sampler (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 rx,
   output logic                 rx_vld,
   output uart_pkg::rx_result_t rx_res
);

   uart_pkg::rx_state_t               state;
   logic                              rx_meta;
   logic                              rx_sync;
   logic                              rx_d;
   logic                              fall;
   logic [uart_pkg::tmr_w-1:0]        bit_tmr;
   logic [uart_pkg::cnt_w-1:0]        bit_cnt;
   logic [uart_pkg::data_bits-1:0]    data_q;
   logic                              par_q;
   logic                              tick;
   logic                              stop_tick;

   // ============================================================
   // synchronizer and edge detect
   // ============================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_d    <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
         rx_d    <= rx_sync;
      end
   end

   assign fall      = rx_d && !rx_sync;
   assign tick      = (bit_tmr == uart_pkg::bit_last);
   assign stop_tick = (state == uart_pkg::rx_stop) && tick;

   // ============================================================
   // frame FSM
   // ============================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state   <= uart_pkg::rx_idle;
         bit_tmr <= '0;
         bit_cnt <= '0;
      end else begin
         unique case (state)
            uart_pkg::rx_idle: begin
               bit_tmr <= '0;
               if (fall) begin
                  state <= uart_pkg::rx_start;
               end
            end
            uart_pkg::rx_start: begin
               if (bit_tmr == uart_pkg::half_last) begin
                  bit_tmr <= '0;
                  bit_cnt <= '0;
                  // high at mid start bit means it was a glitch
                  state <= (rx_sync == uart_pkg::start_bit) ? uart_pkg::rx_data
                                                            : uart_pkg::rx_idle;
               end else begin
                  bit_tmr <= bit_tmr + 1'b1;
               end
            end
            uart_pkg::rx_data: begin
               if (tick) begin
                  bit_tmr <= '0;
                  if (bit_cnt == uart_pkg::data_last) begin
                     state <= uart_pkg::rx_parity;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end else begin
                  bit_tmr <= bit_tmr + 1'b1;
               end
            end
            uart_pkg::rx_parity: begin
               if (tick) begin
                  bit_tmr <= '0;
                  state   <= uart_pkg::rx_stop;
               end else begin
                  bit_tmr <= bit_tmr + 1'b1;
               end
            end
            uart_pkg::rx_stop: begin
               if (tick) begin
                  bit_tmr <= '0;
                  state   <= uart_pkg::rx_idle;  // mid stop bit, ready for next edge
               end else begin
                  bit_tmr <= bit_tmr + 1'b1;
               end
            end
            default: begin
               state <= uart_pkg::rx_idle;
            end
         endcase
      end
   end

   // ============================================================
   // data capture and result
   // ============================================================

   always_ff @(posedge clk) begin
      if ((state == uart_pkg::rx_data) && tick) begin
         data_q <= {rx_sync, data_q[uart_pkg::data_bits-1:1]};  // lsb first
      end
      if ((state == uart_pkg::rx_parity) && tick) begin
         par_q <= rx_sync;
      end
      if (stop_tick) begin
         rx_res.data       <= data_q;
         rx_res.parity_err <= ~^{data_q, par_q};   // odd parity over data + parity
         rx_res.frame_err  <= (rx_sync != uart_pkg::stop_bit);
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_vld <= 1'b0;
      end else begin
         rx_vld <= stop_tick;
      end
   end

endmodule

// File: rtl/uart_tx_shifter.sv
`timescale 1ns/1ps

module uart_tx_shifter (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              tx_req,
   input  uart_pkg::tx_req_t tx_byte,
   output logic              tx_ack,
   output logic              tx
);

   logic                              busy;
   logic [uart_pkg::tmr_w-1:0]        bit_tmr;
   logic [uart_pkg::cnt_w-1:0]        bit_cnt;
   logic [uart_pkg::frame_bits-1:0]   frame_q;
   logic                              start_frame;
   logic                              bit_end;
   logic                              last_bit;

   // a request is only taken once the previous ack has been released
   assign start_frame = tx_req && !busy && !tx_ack;
   assign bit_end     = busy && (bit_tmr == uart_pkg::bit_last);
   assign last_bit    = (bit_cnt == uart_pkg::frame_last);

   // ============================================================
   // frame register
   // ============================================================

   always_ff @(posedge clk) begin
      if (start_frame) begin
         frame_q <= {uart_pkg::stop_bit,
                     ~^tx_byte.data,              // odd parity
                     tx_byte.data,
                     uart_pkg::start_bit};
      end else if (bit_end) begin
         frame_q <= {uart_pkg::stop_bit, frame_q[uart_pkg::frame_bits-1:1]};
      end
   end

   // ============================================================
   // bit timer and counter
   // ============================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy    <= 1'b0;
         bit_tmr <= '0;
         bit_cnt <= '0;
      end else if (start_frame) begin
         busy    <= 1'b1;
         bit_tmr <= '0;
         bit_cnt <= '0;
      end else if (busy) begin
         if (bit_end) begin
            bit_tmr <= '0;
            if (last_bit) begin
               busy <= 1'b0;                   // stop bit done
            end else begin
               bit_cnt <= bit_cnt + 1'b1;
            end
         end else begin
            bit_tmr <= bit_tmr + 1'b1;
         end
      end
   end

   // ============================================================
   // line driver and ack phase
   // ============================================================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx <= uart_pkg::stop_bit;
      end else if (start_frame) begin
         tx <= uart_pkg::start_bit;
      end else if (bit_end) begin
         tx <= frame_q[1];
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx_ack <= 1'b0;
      end else if (bit_end && last_bit) begin
         tx_ack <= 1'b1;
      end else if (tx_ack && !tx_req) begin
         tx_ack <= 1'b0;                       // requester has dropped req
      end
   end

endmodule

// File: rtl/uart_pkg.sv
package uart_pkg;

   // ============================================================
   // bit timing
   // ============================================================

   localparam int clks_per_bit = 8;             // kept short for simulation, any value >= 4
   localparam int half_bit = clks_per_bit / 2;  // start bit confirm point
   localparam int tmr_w = $clog2(clks_per_bit);

   localparam logic [tmr_w-1:0] bit_last = tmr_w'(clks_per_bit - 1);
   localparam logic [tmr_w-1:0] half_last = tmr_w'(half_bit - 1);

   // ============================================================
   // frame layout
   // ============================================================

   localparam int data_bits = 8;
   localparam int frame_bits = data_bits + 3;   // start + data + parity + stop
   localparam int cnt_w = $clog2(frame_bits);

   localparam logic [cnt_w-1:0] frame_last = cnt_w'(frame_bits - 1);
   localparam logic [cnt_w-1:0] data_last = cnt_w'(data_bits - 1);

   localparam logic start_bit = 1'b0;
   localparam logic stop_bit = 1'b1;            // also the idle line level

   // ============================================================
   // shared types
   // ============================================================

   typedef struct packed {
      logic [data_bits-1:0] data;
   } tx_req_t;

   typedef struct packed {
      logic [data_bits-1:0] data;
      logic                 parity_err;
      logic                 frame_err;
   } rx_result_t;

   typedef enum logic [2:0] {
      idle,
      send_lo,
      wait_lo,
      send_hi,
      wait_hi
   } ctrl_state_t;

   typedef enum logic [2:0] {
      rx_idle,
      rx_start,
      rx_data,
      rx_parity,
      rx_stop
   } rx_state_t;

endpackage
